//--- files.f
+incdir+tests
common/core_pkg.sv
regfile/register_file.sv
design/instr_decode.sv
design/alu_execute.sv
design/reg_debug_axil.sv
design/core_top.sv
tests/core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
SIM_BIN=core_sim

verilator --binary --timing -f files.f --top-module core_tb -Mdir "$BUILD_DIR" -o "$SIM_BIN"
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/$SIM_BIN" > "$LOG_FILE" 2>&1
status=$?
cat "$LOG_FILE"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation completed successfully" "$LOG_FILE"; then
	exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1

//--- tests/core_model.svh
`ifndef CORE_MODEL_SVH
`define CORE_MODEL_SVH

// Architectural register state, register 0 is never written
word_t model_regs [NUM_REGS];

////////////////////
// Instruction encoding
////////////////////
function automatic instr_t encode_rtype(input logic [5:0] funct, input reg_addr_t rs,
	input reg_addr_t rt, input reg_addr_t rd, input logic [4:0] shamt);
	return {OP_RTYPE, rs, rt, rd, shamt, funct};
endfunction

function automatic instr_t encode_itype(input logic [5:0] opcode, input reg_addr_t rs,
	input reg_addr_t rt, input logic [15:0] imm);
	return {opcode, rs, rt, imm};
endfunction

task automatic clear_model();
	for (int i = 0; i < NUM_REGS; i++)
		model_regs[i] = '0;
endtask

////////////////////
// ISA subset
////////////////////
task automatic apply_to_model(input instr_t w);
	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  shamt;
	logic [15:0] imm;
	reg_addr_t   rs;
	reg_addr_t   rt;
	reg_addr_t   dest;
	word_t       a;
	word_t       b;
	word_t       result;
	logic        write;

	opcode = w[31:26];
	rs     = w[25:21];
	rt     = w[20:16];
	shamt  = w[10:6];
	funct  = w[5:0];
	imm    = w[15:0];
	a      = model_regs[rs];
	b      = model_regs[rt];
	result = '0;
	write  = 1'b1;
	// R-type writes rd, I-type writes rt
	dest   = w[15:11];
	case (opcode)
		OP_RTYPE:
		begin
			case (funct)
				FN_ADD:  result = a + b;
				FN_SUB:  result = a - b;
				FN_AND:  result = a & b;
				FN_OR:   result = a | b;
				FN_XOR:  result = a ^ b;
				FN_SLT:  result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				FN_SLL:  result = b << shamt;
				FN_SRL:  result = b >> shamt;
				default: write = 1'b0;
			endcase
		end
		OP_ADDI:
		begin
			dest   = rt;
			result = a + {{16{imm[15]}}, imm};
		end
		OP_ANDI:
		begin
			dest   = rt;
			result = a & {16'h0000, imm};
		end
		OP_ORI:
		begin
			dest   = rt;
			result = a | {16'h0000, imm};
		end
		OP_LUI:
		begin
			dest   = rt;
			result = {imm, 16'h0000};
		end
		default: write = 1'b0;
	endcase
	if (write && (dest != '0))
		model_regs[dest] = result;
endtask

`endif

//--- tests/core_tb.sv
`timescale 1ns/1ps

module core_tb;
	import core_pkg::*;

	`include "core_model.svh"

	localparam int WAIT_LIMIT = 20;
	localparam int PROGRAM_LEN = 300;

	logic                  clk;
	logic                  rst;
	logic                  run;
	logic                  instr_valid;
	instr_t                instr;
	logic [DBG_ADDR_W-1:0] araddr;
	logic                  arvalid;
	logic                  arready;
	word_t                 rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;

	string current_test;
	int    test_errors;
	int    error_count;
	int    test_count;
	int    failed_tests;
	logic  timed_out;

	core_top UUT (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.instr_valid (instr_valid),
		.instr       (instr),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.rready      (rready)
	);

	always #20 clk = ~clk;

	// A hung handshake ends the run here
	always @(posedge timed_out)
	begin
		$display("Simulation failed");
		$finish;
	end

	////////////////////
	// Reporting
	////////////////////
	task automatic report_mismatch(input string what, input word_t expected, input word_t actual);
		$display("[FAIL] %s %s: expected 0x%08h, actual 0x%08h", current_test, what,
			expected, actual);
		test_errors++;
		error_count++;
	endtask

	task automatic report_problem(input string msg);
		$display("ERROR in test %s: %s", current_test, msg);
		test_errors++;
		error_count++;
	endtask

	task automatic report_timeout(input string msg);
		$display("ERROR in test %s: timed out while %s", current_test, msg);
		test_errors++;
		error_count++;
		timed_out = 1'b1;
	endtask

	task automatic start_test(input string name);
		current_test = name;
		test_errors  = 0;
	endtask

	task automatic finish_test();
		test_count++;
		if (test_errors == 0)
			$display("Test %s: passed", current_test);
		else
		begin
			$display("Test %s: FAILED with %0d errors", current_test, test_errors);
			failed_tests++;
		end
	endtask

	////////////////////
	// Stimulus helpers
	////////////////////
	task automatic wait_cycles(input int n);
		repeat (n) @(negedge clk);
	endtask

	// Called on a falling edge with run high
	task automatic issue_instr(input instr_t w);
		instr       = w;
		instr_valid = 1'b1;
		apply_to_model(w);
		@(negedge clk);
	endtask

	function automatic instr_t random_instr();
		logic [31:0] pick;
		logic [31:0] bits;
		reg_addr_t   rs;
		reg_addr_t   rt;
		reg_addr_t   rd;
		logic [15:0] imm;
		logic [4:0]  shamt;
		instr_t      w;

		pick  = $urandom_range(12, 0);
		bits  = $urandom;
		// Registers 0 to 7 only, so dependencies are frequent
		rs    = {2'b00, bits[2:0]};
		rt    = {2'b00, bits[5:3]};
		rd    = {2'b00, bits[8:6]};
		imm   = bits[24:9];
		shamt = bits[29:25];
		case (pick)
			0:       w = encode_rtype(FN_ADD, rs, rt, rd, 5'd0);
			1:       w = encode_rtype(FN_SUB, rs, rt, rd, 5'd0);
			2:       w = encode_rtype(FN_AND, rs, rt, rd, 5'd0);
			3:       w = encode_rtype(FN_OR, rs, rt, rd, 5'd0);
			4:       w = encode_rtype(FN_XOR, rs, rt, rd, 5'd0);
			5:       w = encode_rtype(FN_SLT, rs, rt, rd, 5'd0);
			6:       w = encode_rtype(FN_SLL, 5'd0, rt, rd, shamt);
			7:       w = encode_rtype(FN_SRL, 5'd0, rt, rd, shamt);
			8:       w = encode_itype(OP_ADDI, rs, rt, imm);
			9:       w = encode_itype(OP_ANDI, rs, rt, imm);
			10:      w = encode_itype(OP_ORI, rs, rt, imm);
			11:      w = encode_itype(OP_LUI, 5'd0, rt, imm);
			// Unused opcode, must act as a no-op
			default: w = encode_itype(6'h3F, rs, rt, imm);
		endcase
		return w;
	endfunction

	////////////////////
	// AXI4-Lite read
	////////////////////
	task automatic axi_read(input logic [DBG_ADDR_W-1:0] addr, input int hold,
		output word_t data, output logic [1:0] resp);
		int         waited;
		word_t      first_data;
		logic [1:0] first_resp;

		data    = '0;
		resp    = '0;
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b0;
		waited  = 0;
		while (!arready && (waited < WAIT_LIMIT))
		begin
			@(negedge clk);
			waited++;
		end
		if (!arready)
		begin
			report_timeout("waiting for arready");
			return;
		end
		// Address handshake on the next rising edge
		@(negedge clk);
		arvalid = 1'b0;
		if (arready !== 1'b0)
			report_problem("arready stayed high after the address was accepted");
		waited = 0;
		while (!rvalid && (waited < WAIT_LIMIT))
		begin
			@(negedge clk);
			waited++;
		end
		if (!rvalid)
		begin
			report_timeout("waiting for rvalid");
			return;
		end
		first_data = rdata;
		first_resp = rresp;
		// Response must hold while rready is low
		for (int i = 0; i < hold; i++)
		begin
			@(negedge clk);
			if (rvalid !== 1'b1)
				report_problem("rvalid dropped while rready was low");
			if (rdata !== first_data)
				report_mismatch("rdata during hold", first_data, rdata);
			if (rresp !== first_resp)
				report_mismatch("rresp during hold", 32'(first_resp), 32'(rresp));
			if (arready !== 1'b0)
				report_problem("arready rose before the data handshake");
		end
		rready = 1'b1;
		@(negedge clk);
		rready = 1'b0;
		if (rvalid !== 1'b0)
			report_problem("rvalid stayed high after the data handshake");
		if (arready !== 1'b1)
			report_problem("arready did not return after the data handshake");
		data = first_data;
		resp = first_resp;
	endtask

	task automatic check_all_regs();
		word_t      data;
		logic [1:0] resp;

		for (int i = 0; i < NUM_REGS; i++)
		begin
			axi_read(7'(i * 4), 0, data, resp);
			if (data !== model_regs[i])
				report_mismatch($sformatf("r%0d", i), model_regs[i], data);
			if (resp !== AXI_RESP_OKAY)
				report_mismatch($sformatf("r%0d rresp", i), 32'(AXI_RESP_OKAY), 32'(resp));
		end
	endtask

	////////////////////
	// Test sequence
	////////////////////
	initial
	begin
		word_t                 data;
		logic [1:0]            resp;
		int                    hold;
		int                    idx;
		instr_t                held;
		logic [DBG_ADDR_W-1:0] bad_addr;

		clk          = 1'b0;
		rst          = 1'b1;
		run          = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b0;
		timed_out    = 1'b0;
		test_errors  = 0;
		error_count  = 0;
		test_count   = 0;
		failed_tests = 0;
		current_test = "setup";
		void'($urandom(32'h1632));
		clear_model();

		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		start_test("reset_clear");
		if (arready !== 1'b1)
			report_problem("arready is low after reset");
		if (rvalid !== 1'b0)
			report_problem("rvalid is high after reset");
		check_all_regs();
		finish_test();

		// Back-to-back program, no idle cycles
		start_test("random_program");
		for (int n = 0; n < PROGRAM_LEN; n++)
			issue_instr(random_instr());
		instr_valid = 1'b0;
		wait_cycles(3);
		check_all_regs();
		finish_test();

		start_test("reg_zero");
		issue_instr(encode_itype(OP_LUI, 5'd0, 5'd1, 16'h8421));
		issue_instr(encode_itype(OP_ORI, 5'd0, 5'd2, 16'h00F0));
		issue_instr(encode_itype(OP_LUI, 5'd0, 5'd0, 16'hABCD));
		issue_instr(encode_itype(OP_ORI, 5'd1, 5'd0, 16'h1234));
		issue_instr(encode_rtype(FN_ADD, 5'd1, 5'd2, 5'd0, 5'd0));
		// Readers of r0 right behind the discarded writes
		issue_instr(encode_rtype(FN_OR, 5'd0, 5'd1, 5'd3, 5'd0));
		issue_instr(encode_rtype(FN_XOR, 5'd0, 5'd2, 5'd4, 5'd0));
		issue_instr(encode_rtype(FN_SLL, 5'd0, 5'd0, 5'd5, 5'd3));
		issue_instr(encode_itype(OP_ADDI, 5'd0, 5'd6, 16'h0007));
		instr_valid = 1'b0;
		wait_cycles(3);
		check_all_regs();
		finish_test();

		start_test("run_hold");
		issue_instr(encode_itype(OP_LUI, 5'd0, 5'd2, 16'h0010));
		instr_valid = 1'b0;
		wait_cycles(3);
		held        = encode_itype(OP_ADDI, 5'd2, 5'd2, 16'h0001);
		run         = 1'b0;
		instr       = held;
		instr_valid = 1'b1;
		hold        = $urandom_range(8, 3);
		wait_cycles(hold);
		axi_read(7'd8, 0, data, resp);
		if (data !== model_regs[2])
			report_mismatch("r2 while held", model_regs[2], data);
		run = 1'b1;
		apply_to_model(held);
		@(negedge clk);
		instr_valid = 1'b0;
		wait_cycles(3);
		check_all_regs();
		// Freeze with two instructions still in flight
		issue_instr(encode_itype(OP_ADDI, 5'd2, 5'd3, 16'h0100));
		issue_instr(encode_itype(OP_ADDI, 5'd3, 5'd3, 16'h0001));
		held  = encode_itype(OP_ADDI, 5'd3, 5'd4, 16'h0002);
		run   = 1'b0;
		instr = held;
		hold  = $urandom_range(8, 3);
		wait_cycles(hold);
		run = 1'b1;
		apply_to_model(held);
		@(negedge clk);
		instr_valid = 1'b0;
		wait_cycles(3);
		check_all_regs();
		finish_test();

		start_test("debug_protocol");
		// Out-of-range addresses index r31, so give it a nonzero value
		issue_instr(encode_itype(OP_LUI, 5'd0, 5'd31, 16'hA5C3));
		instr_valid = 1'b0;
		wait_cycles(3);
		bad_addr = 7'($urandom_range(127, 125));
		hold     = $urandom_range(6, 1);
		axi_read(bad_addr, hold, data, resp);
		if (resp !== AXI_RESP_SLVERR)
			report_mismatch("rresp out of range", 32'(AXI_RESP_SLVERR), 32'(resp));
		if (data !== '0)
			report_mismatch("rdata out of range", 32'h0, data);
		idx  = $urandom_range(7, 1);
		hold = $urandom_range(6, 1);
		axi_read(7'(idx * 4), hold, data, resp);
		if (data !== model_regs[idx])
			report_mismatch($sformatf("r%0d held read", idx), model_regs[idx], data);
		if (resp !== AXI_RESP_OKAY)
			report_mismatch("rresp in range", 32'(AXI_RESP_OKAY), 32'(resp));
		finish_test();

		$display("Tests run: %0d, tests failed: %0d, errors: %0d", test_count, failed_tests,
			error_count);
		if (error_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- design/core_top.sv
`timescale 1ns/1ps

module core_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           run,
	input  logic                           instr_valid,
	input  core_pkg::instr_t               instr,
	input  logic [core_pkg::DBG_ADDR_W-1:0] araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output core_pkg::word_t                rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready
);
	import core_pkg::*;

	reg_addr_t rs_addr;
	reg_addr_t rt_addr;
	reg_addr_t dbg_addr;
	word_t     rs_data;
	word_t     rt_data;
	word_t     dbg_data;
	decoded_t  dec;
	wb_t       wb;

	////////////////////
	// Pipeline stages
	////////////////////
	instr_decode u_decode (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.instr_valid (instr_valid),
		.instr       (instr),
		.rs_addr     (rs_addr),
		.rt_addr     (rt_addr),
		.rs_data     (rs_data),
		.rt_data     (rt_data),
		.dec         (dec)
	);

	alu_execute u_execute (
		.clk (clk),
		.rst (rst),
		.run (run),
		.dec (dec),
		.wb  (wb)
	);

	// Write-back stage lives in the register file
	register_file u_regfile (
		.clk      (clk),
		.rst      (rst),
		.rs1_addr (rs_addr),
		.rs2_addr (rt_addr),
		.dbg_addr (dbg_addr),
		.wb       (wb),
		.run      (run),
		.rs1_data (rs_data),
		.rs2_data (rt_data),
		.dbg_data (dbg_data)
	);

	////////////////////
	// Debug read slave
	////////////////////
	reg_debug_axil u_debug (
		.clk      (clk),
		.rst      (rst),
		.araddr   (araddr),
		.arvalid  (arvalid),
		.arready  (arready),
		.rdata    (rdata),
		.rresp    (rresp),
		.rvalid   (rvalid),
		.rready   (rready),
		.dbg_addr (dbg_addr),
		.dbg_data (dbg_data)
	);

endmodule

//--- design/reg_debug_axil.sv
`timescale 1ns/1ps

module reg_debug_axil (
	input  logic                           clk,
	input  logic                           rst,
	input  logic [core_pkg::DBG_ADDR_W-1:0] araddr,
	input  logic                           arvalid,
	output logic                           arready,
	output core_pkg::word_t                rdata,
	output logic [1:0]                     rresp,
	output logic                           rvalid,
	input  logic                           rready,
	output core_pkg::reg_addr_t            dbg_addr,
	input  core_pkg::word_t                dbg_data
);
	import core_pkg::*;

	typedef enum logic {
		IDLE,
		RESP
	} state_t;

	state_t    state;
	reg_addr_t idx_q;
	logic      err_q;
	logic      ar_hs;

	assign arready  = (state == IDLE);
	assign ar_hs    = arvalid && arready;
	assign dbg_addr = idx_q;
	assign rresp    = err_q ? AXI_RESP_SLVERR : AXI_RESP_OKAY;

	////////////////////
	// Read FSM
	////////////////////
	// RESP with rvalid low is the capture cycle
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state  <= IDLE;
			rvalid <= 1'b0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (ar_hs)
						state <= RESP;
				end
				RESP:
				begin
					if (!rvalid)
						rvalid <= 1'b1;
					else if (rready)
					begin
						rvalid <= 1'b0;
						state  <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Address and data registers
	always_ff @(posedge clk)
	begin
		if (ar_hs)
		begin
			idx_q <= araddr[6:2];
			err_q <= araddr > DBG_LAST_ADDR;
		end
		if ((state == RESP) && !rvalid)
			rdata <= err_q ? '0 : dbg_data;
	end

endmodule

//--- design/alu_execute.sv
`timescale 1ns/1ps

module alu_execute (
	input  logic               clk,
	input  logic               rst,
	input  logic               run,
	input  core_pkg::decoded_t dec,
	output core_pkg::wb_t      wb
);
	import core_pkg::*;

	logic  fwd_a;
	logic  fwd_b;
	word_t src_a;
	word_t src_b;
	word_t result;

	////////////////////
	// Forwarding
	////////////////////
	// The registered result is one instruction older than dec
	assign fwd_a = wb.we && (wb.dest == dec.rs);
	// An immediate in op_b is never replaced
	assign fwd_b = wb.we && !dec.use_imm && (wb.dest == dec.rt);

	assign src_a = fwd_a ? wb.data : dec.op_a;
	assign src_b = fwd_b ? wb.data : dec.op_b;

	////////////////////
	// ALU
	////////////////////
	always_comb
	begin
		case (dec.alu_op)
			ALU_ADD: result = src_a + src_b;
			ALU_SUB: result = src_a - src_b;
			ALU_AND: result = src_a & src_b;
			ALU_OR:  result = src_a | src_b;
			ALU_XOR: result = src_a ^ src_b;
			// Signed compare
			ALU_SLT: result = {31'b0, $signed(src_a) < $signed(src_b)};
			ALU_SLL: result = src_a << src_b[4:0];
			ALU_SRL: result = src_a >> src_b[4:0];
			// Upper half already placed by decode
			ALU_LUI: result = src_b;
			default: result = '0;
		endcase
	end

	// Write-back record
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb.we <= 1'b0;
		end
		else if (run)
		begin
			wb.we   <= dec.valid;
			wb.dest <= dec.dest;
			wb.data <= result;
		end
	end

endmodule

//--- design/instr_decode.sv
`timescale 1ns/1ps

module instr_decode (
	input  logic                clk,
	input  logic                rst,
	input  logic                run,
	input  logic                instr_valid,
	input  core_pkg::instr_t    instr,
	output core_pkg::reg_addr_t rs_addr,
	output core_pkg::reg_addr_t rt_addr,
	input  core_pkg::word_t     rs_data,
	input  core_pkg::word_t     rt_data,
	output core_pkg::decoded_t  dec
);
	import core_pkg::*;

	logic [5:0]  opcode;
	logic [5:0]  funct;
	logic [4:0]  shamt;
	logic [15:0] imm16;
	reg_addr_t   f_rs;
	reg_addr_t   f_rt;
	reg_addr_t   f_rd;

	logic        known;
	logic        use_imm;
	alu_op_t     alu_op;
	reg_addr_t   dest;
	reg_addr_t   src_a;
	word_t       imm;
	decoded_t    dec_next;

	// Instruction fields
	assign opcode = instr[31:26];
	assign f_rs   = instr[25:21];
	assign f_rt   = instr[20:16];
	assign f_rd   = instr[15:11];
	assign shamt  = instr[10:6];
	assign funct  = instr[5:0];
	assign imm16  = instr[15:0];

	////////////////////
	// Opcode decode
	////////////////////
	always_comb
	begin
		known   = 1'b1;
		use_imm = 1'b0;
		alu_op  = ALU_ADD;
		dest    = f_rd;
		src_a   = f_rs;
		imm     = '0;
		case (opcode)
			OP_RTYPE:
			begin
				case (funct)
					FN_ADD: alu_op = ALU_ADD;
					FN_SUB: alu_op = ALU_SUB;
					FN_AND: alu_op = ALU_AND;
					FN_OR:  alu_op = ALU_OR;
					FN_XOR: alu_op = ALU_XOR;
					FN_SLT: alu_op = ALU_SLT;
					FN_SLL, FN_SRL:
					begin
						// Shifts move rt by shamt
						alu_op  = (funct == FN_SLL) ? ALU_SLL : ALU_SRL;
						src_a   = f_rt;
						use_imm = 1'b1;
						imm     = {27'b0, shamt};
					end
					default: known = 1'b0;
				endcase
			end
			OP_ADDI:
			begin
				dest    = f_rt;
				use_imm = 1'b1;
				imm     = {{16{imm16[15]}}, imm16};
			end
			OP_ANDI, OP_ORI:
			begin
				alu_op  = (opcode == OP_ANDI) ? ALU_AND : ALU_OR;
				dest    = f_rt;
				use_imm = 1'b1;
				imm     = {16'b0, imm16};
			end
			OP_LUI:
			begin
				alu_op  = ALU_LUI;
				dest    = f_rt;
				use_imm = 1'b1;
				imm     = {imm16, 16'b0};
			end
			default: known = 1'b0;
		endcase
	end

	assign rs_addr = src_a;
	assign rt_addr = f_rt;

	always_comb
	begin
		// Unknown ops and writes to register 0 become no-ops
		dec_next.valid   = instr_valid && known && (dest != '0);
		dec_next.alu_op  = alu_op;
		dec_next.rs      = src_a;
		dec_next.rt      = f_rt;
		dec_next.dest    = dest;
		dec_next.op_a    = rs_data;
		dec_next.op_b    = use_imm ? imm : rt_data;
		dec_next.use_imm = use_imm;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			dec.valid <= 1'b0;
		else if (run)
			dec <= dec_next;
	end

endmodule

//--- regfile/register_file.sv
`timescale 1ns/1ps

module register_file (
	input  logic              clk,
	input  logic              rst,
	input  core_pkg::reg_addr_t rs1_addr,
	input  core_pkg::reg_addr_t rs2_addr,
	input  core_pkg::reg_addr_t dbg_addr,
	input  core_pkg::wb_t     wb,
	input  logic              run,
	output core_pkg::word_t   rs1_data,
	output core_pkg::word_t   rs2_data,
	output core_pkg::word_t   dbg_data
);
	import core_pkg::*;

	word_t bank [NUM_REGS];
	logic  wr_en;

	// Writes only happen while the pipeline runs
	assign wr_en = run && wb.we;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				bank[i] <= '0;
		end
		else if (wr_en)
		begin
			bank[wb.dest] <= wb.data;
		end
	end

	////////////////////
	// Read ports
	////////////////////
	// Register 0 reads zero, a write in progress passes straight through
	function automatic word_t read_port(input reg_addr_t addr);
		if (addr == '0)
			return '0;
		else if (wr_en && (wb.dest == addr))
			return wb.data;
		else
			return bank[addr];
	endfunction

	always_comb
	begin
		rs1_data = read_port(rs1_addr);
		rs2_data = read_port(rs2_addr);
		dbg_data = read_port(dbg_addr);
	end

endmodule

//--- common/core_pkg.sv
package core_pkg;

	////////////////////
	// Widths and basic types
	////////////////////
	localparam int NUM_REGS = 32;
	localparam int DBG_ADDR_W = 7;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [31:0] instr_t;
	typedef logic [3:0]  alu_op_t;

	////////////////////
	// MIPS opcodes and function codes
	////////////////////
	localparam logic [5:0] OP_RTYPE = 6'h00;
	localparam logic [5:0] OP_ADDI  = 6'h08;
	localparam logic [5:0] OP_ANDI  = 6'h0C;
	localparam logic [5:0] OP_ORI   = 6'h0D;
	localparam logic [5:0] OP_LUI   = 6'h0F;

	localparam logic [5:0] FN_SLL = 6'h00;
	localparam logic [5:0] FN_SRL = 6'h02;
	localparam logic [5:0] FN_ADD = 6'h20;
	localparam logic [5:0] FN_SUB = 6'h22;
	localparam logic [5:0] FN_AND = 6'h24;
	localparam logic [5:0] FN_OR  = 6'h25;
	localparam logic [5:0] FN_XOR = 6'h26;
	localparam logic [5:0] FN_SLT = 6'h2A;

	// ALU operations
	localparam alu_op_t ALU_ADD = 4'd0;
	localparam alu_op_t ALU_SUB = 4'd1;
	localparam alu_op_t ALU_AND = 4'd2;
	localparam alu_op_t ALU_OR  = 4'd3;
	localparam alu_op_t ALU_XOR = 4'd4;
	localparam alu_op_t ALU_SLT = 4'd5;
	localparam alu_op_t ALU_SLL = 4'd6;
	localparam alu_op_t ALU_SRL = 4'd7;
	localparam alu_op_t ALU_LUI = 4'd8;

	// Debug bus responses and last valid register address
	localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
	localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;
	localparam logic [DBG_ADDR_W-1:0] DBG_LAST_ADDR = 7'h7C;

	////////////////////
	// Stage records
	////////////////////
	// rs names the register behind op_a, which is rt for the shifts
	typedef struct packed {
		logic      valid;
		alu_op_t   alu_op;
		reg_addr_t rs;
		reg_addr_t rt;
		reg_addr_t dest;
		word_t     op_a;
		word_t     op_b;
		logic      use_imm;
	} decoded_t;

	typedef struct packed {
		logic      we;
		reg_addr_t dest;
		word_t     data;
	} wb_t;

endpackage
